// ==== src/l1d_cfg.svh ====
`ifndef L1D_CFG_SVH
`define L1D_CFG_SVH

// =========================================================
// Cache geometry
// =========================================================

// Address and data path width
`define L1D_ADDR_W   32

// 64 lines
`define L1D_INDEX_W  6

`define L1D_OFFSET_W 4   // 16-byte lines
`define L1D_WORDS    4   // Words per line

`endif

// ==== src/l1d_pkg.sv ====
`default_nettype none

package l1d_pkg;

  `include "l1d_cfg.svh"

  // =========================================================
  // Address and data vectors
  // =========================================================
  typedef logic [`L1D_ADDR_W-1:0] addr_t;
  typedef logic [`L1D_ADDR_W-1:0] word_t;

  // Tag is whatever sits above index and offset
  typedef logic [`L1D_ADDR_W-`L1D_INDEX_W-`L1D_OFFSET_W-1:0] tag_t;
  typedef logic [`L1D_INDEX_W-1:0] index_t;
  typedef logic [$clog2(`L1D_WORDS)-1:0] word_sel_t;

  typedef logic [`L1D_WORDS*`L1D_ADDR_W-1:0] line_t;
  typedef logic [`L1D_WORDS*`L1D_ADDR_W/8-1:0] line_mask_t;  // One bit per byte

  // Access size as seen on core_type and mem_type
  typedef enum logic [2:0] {
    size_byte = 3'd0,
    size_half = 3'd1,
    size_word = 3'd2
  } size_e;

endpackage

`default_nettype wire

// ==== src/l1d_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Captured core request, one producer and two consumers
interface l1d_req_if;
  logic                   valid;  // Pulses the cycle after capture
  logic                   write;
  l1d_pkg::tag_t          tag;
  l1d_pkg::index_t        index;
  l1d_pkg::word_sel_t     word_sel;
  l1d_pkg::size_e         size;
  l1d_pkg::addr_t         addr;
  l1d_pkg::word_t         wdata;  // Raw core word
  l1d_pkg::line_t         line_wdata;
  l1d_pkg::line_mask_t    line_mask;

  modport port (
    output valid, write, tag, index, word_sel, size, addr, wdata,
    output line_wdata, line_mask
  );

  modport sink (
    input valid, write, tag, index, word_sel, size, addr, wdata,
    input line_wdata, line_mask
  );
endinterface

// Controller to memory sequencer
interface l1d_mem_if;
  logic                   fill_start;
  logic                   wt_start;
  l1d_pkg::addr_t         line_addr;
  l1d_pkg::addr_t         wt_addr;
  l1d_pkg::word_t         wt_data;
  l1d_pkg::size_e         wt_size;
  logic                   done;       // One cycle, after the last beat
  l1d_pkg::line_t         fill_line;  // Word 0 in the low bits

  modport ctrl (
    output fill_start, wt_start, line_addr, wt_addr, wt_data, wt_size,
    input  done
  );

  modport port (
    input  fill_start, wt_start, line_addr, wt_addr, wt_data, wt_size,
    output done, fill_line
  );
endinterface

`default_nettype wire

// ==== src/l1d_core_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_core_port (
  input  wire                   clk,
  input  wire                   rst,
  input  wire l1d_pkg::addr_t   core_addr,
  input  wire                   core_req,
  input  wire                   core_write,
  input  wire l1d_pkg::word_t   core_in,
  input  wire l1d_pkg::size_e   core_type,
  input  wire                   accept,
  l1d_req_if.port               req
);

  localparam int unsigned tag_w = $bits(l1d_pkg::tag_t);

  l1d_pkg::addr_t addr_q;
  l1d_pkg::word_t wdata_q;
  l1d_pkg::size_e size_q;
  logic [3:0]     word_mask;   // Byte enables inside one word
  l1d_pkg::word_t word_lanes;  // Data replicated over the enabled lanes

  // =========================================================
  // Capture
  // =========================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      req.valid <= 1'b0;
      req.write <= 1'b0;
    end
    else
    begin
      req.valid <= accept & core_req;  // Marks the array read cycle
      if (accept)
        req.write <= core_write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q  <= core_addr;
      wdata_q <= core_in;
      size_q  <= core_type;
    end
  end

  // Address split
  assign req.addr     = addr_q;
  assign req.tag      = addr_q[`L1D_ADDR_W-1 -: tag_w];
  assign req.index    = addr_q[`L1D_OFFSET_W +: `L1D_INDEX_W];
  assign req.word_sel = addr_q[2 +: $bits(l1d_pkg::word_sel_t)];
  assign req.size     = size_q;
  assign req.wdata    = wdata_q;

  // =========================================================
  // Lane placement
  // =========================================================
  always_comb
  begin
    case (size_q)
      l1d_pkg::size_byte:
      begin
        word_mask  = 4'b0001 << addr_q[1:0];
        word_lanes = {4{wdata_q[7:0]}};
      end
      l1d_pkg::size_half:
      begin
        word_mask  = addr_q[1] ? 4'b1100 : 4'b0011;
        word_lanes = {2{wdata_q[15:0]}};
      end
      l1d_pkg::size_word:
      begin
        word_mask  = 4'b1111;
        word_lanes = wdata_q;
      end
      default:
      begin
        word_mask  = 4'b0000;  // Unknown size writes nothing
        word_lanes = wdata_q;
      end
    endcase
  end

  assign req.line_mask  = l1d_pkg::line_mask_t'(word_mask) << {req.word_sel, 2'b00};
  assign req.line_wdata = {`L1D_WORDS{word_lanes}};

endmodule

`default_nettype wire

// ==== src/l1d_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_line_store (
  input  wire                   clk,
  input  wire                   rst,
  l1d_req_if.sink               req,
  input  wire                   lookup,
  input  wire                   byte_write,
  input  wire                   install,
  input  wire l1d_pkg::line_t   fill_line,
  output logic                  hit,
  output l1d_pkg::word_t        rd_word
);

  localparam int unsigned n_lines = 1 << `L1D_INDEX_W;
  localparam int unsigned n_bytes = `L1D_WORDS * `L1D_ADDR_W / 8;

  logic [n_lines-1:0] valid_arr;
  l1d_pkg::tag_t      tag_arr  [n_lines];
  l1d_pkg::line_t     data_arr [n_lines];

  // Registered read port
  logic               valid_q;
  l1d_pkg::tag_t      tag_q;
  l1d_pkg::line_t     data_q;

  // =========================================================
  // Valid bits
  // =========================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_arr <= '0;
      valid_q   <= 1'b0;
    end
    else
    begin
      valid_q <= valid_arr[req.index];
      if (install)
        valid_arr[req.index] <= 1'b1;  // Nothing clears a line after reset
    end
  end

  // =========================================================
  // Tag and data arrays
  // =========================================================
  always_ff @(posedge clk)
  begin
    tag_q  <= tag_arr[req.index];
    data_q <= data_arr[req.index];
    if (install)
    begin
      tag_arr[req.index]  <= req.tag;
      data_arr[req.index] <= fill_line;
    end
    else if (byte_write)
    begin
      for (int b = 0; b < n_bytes; b++)
      begin
        if (req.line_mask[b])
          data_arr[req.index][b*8 +: 8] <= req.line_wdata[b*8 +: 8];
      end
    end
  end

  // Only meaningful once the read of the captured index has landed
  assign hit = lookup & valid_q & (tag_q == req.tag);

  assign rd_word = data_q[req.word_sel*`L1D_ADDR_W +: `L1D_ADDR_W];

  // A write hit and a refill can never overlap on the array
  a_no_write_during_install: assert property (
    @(posedge clk) disable iff (rst) !(byte_write && install)
  );

endmodule

`default_nettype wire

// ==== src/l1d_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_ctrl (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   core_req,
  input  wire                   core_write,
  output logic                  accept,
  input  wire                   hit,
  input  wire l1d_pkg::word_t   rd_word,
  input  wire l1d_pkg::line_t   fill_line,
  l1d_req_if.sink               req,
  l1d_mem_if.ctrl               mem,
  output logic                  lookup,
  output logic                  byte_write,
  output logic                  install,
  output logic                  core_wait,
  output l1d_pkg::word_t        core_out
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fill,
    st_install,
    st_write_thru,
    st_resp
  } state_e;

  state_e         state;
  state_e         state_nxt;
  l1d_pkg::word_t resp_word;  // Requested word of a refilled line
  logic           read_hit;

  // =========================================================
  // Lookup decode
  // =========================================================
  assign accept     = (state == st_idle) & core_req;
  assign lookup     = (state == st_lookup) & ~req.valid;  // Array data valid now
  assign read_hit   = lookup & ~req.write & hit;
  assign byte_write = lookup & req.write & hit;
  assign install    = (state == st_install);

  // Memory requests
  assign mem.fill_start = lookup & ~req.write & ~hit;
  assign mem.wt_start   = lookup & req.write;  // Write-through on hit and miss
  assign mem.line_addr  = {req.tag, req.index, {`L1D_OFFSET_W{1'b0}}};
  assign mem.wt_addr    = req.addr;
  assign mem.wt_data    = req.wdata;
  assign mem.wt_size    = req.size;

  // =========================================================
  // State machine
  // =========================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:       if (accept) state_nxt = st_lookup;
      st_lookup:
      begin
        if (lookup)
        begin
          if (req.write)
            state_nxt = st_write_thru;
          else if (hit)
            state_nxt = st_idle;
          else
            state_nxt = st_fill;
        end
      end
      st_fill:       if (mem.done) state_nxt = st_install;
      st_install:    state_nxt = st_resp;
      st_write_thru: if (mem.done) state_nxt = st_idle;
      st_resp:       state_nxt = st_idle;
      default:       state_nxt = st_idle;
    endcase
  end

  // Response word picked straight from the refilled line
  always_ff @(posedge clk)
  begin
    if (install)
      resp_word <= fill_line[req.word_sel*`L1D_ADDR_W +: `L1D_ADDR_W];
  end

  // Core handshake
  always_comb
  begin
    case (state)
      st_idle:       core_wait = core_req;
      st_lookup:     core_wait = ~read_hit;
      st_write_thru: core_wait = ~mem.done;
      st_resp:       core_wait = 1'b0;
      default:       core_wait = 1'b1;
    endcase
  end

  assign core_out = (state == st_resp) ? resp_word : rd_word;

  // Memory done only ever answers an operation in flight
  a_done_in_flight: assert property (
    @(posedge clk) disable iff (rst)
    mem.done |-> (state == st_fill || state == st_write_thru)
  );

  // Core must hold its request while the cache works on it
  a_core_holds_dir: assert property (
    @(posedge clk) disable iff (rst)
    (state != st_idle && core_req) |-> (core_write == req.write)
  );

endmodule

`default_nettype wire

// ==== src/l1d_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_mem_port (
  input  wire                   clk,
  input  wire                   rst,
  l1d_mem_if.port               mem,
  input  wire l1d_pkg::word_t   mem_rdata,
  input  wire                   mem_wait,
  output logic                  mem_req,
  output l1d_pkg::addr_t        mem_addr,
  output logic                  mem_write,
  output l1d_pkg::word_t        mem_wdata,
  output l1d_pkg::size_e        mem_type
);

  localparam l1d_pkg::word_sel_t last_beat = l1d_pkg::word_sel_t'(`L1D_WORDS - 1);

  logic               busy;
  logic               is_write;
  logic               done_q;
  l1d_pkg::word_sel_t beat;
  l1d_pkg::addr_t     addr_q;
  l1d_pkg::word_t     wdata_q;
  l1d_pkg::size_e     size_q;
  l1d_pkg::line_t     line_q;
  logic               beat_ok;
  logic               last;

  assign beat_ok = busy & ~mem_wait;
  assign last    = is_write | (beat == last_beat);  // Write-through is one beat

  // =========================================================
  // Beat sequencing
  // =========================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      is_write <= 1'b0;
      done_q   <= 1'b0;
      beat     <= '0;
    end
    else
    begin
      done_q <= beat_ok & last;
      if (mem.fill_start || mem.wt_start)
      begin
        busy     <= 1'b1;
        is_write <= mem.wt_start;
        beat     <= '0;
      end
      else if (beat_ok)
      begin
        if (last)
          busy <= 1'b0;
        else
          beat <= beat + 1'b1;
      end
    end
  end

  // Beat payload, only moves on a start or a completed beat
  always_ff @(posedge clk)
  begin
    if (mem.fill_start)
    begin
      addr_q <= mem.line_addr;
      size_q <= l1d_pkg::size_word;
    end
    else if (mem.wt_start)
    begin
      addr_q  <= mem.wt_addr;
      wdata_q <= mem.wt_data;
      size_q  <= mem.wt_size;
    end
    else if (beat_ok && !last)
      addr_q <= addr_q + l1d_pkg::addr_t'(`L1D_ADDR_W / 8);  // Next word

    if (beat_ok && !is_write)
      line_q <= {mem_rdata, line_q[$bits(l1d_pkg::line_t)-1:`L1D_ADDR_W]};
  end

  // =========================================================
  // Outputs
  // =========================================================
  assign mem_req       = busy;
  assign mem_write     = busy & is_write;
  assign mem_addr      = addr_q;
  assign mem_wdata     = wdata_q;
  assign mem_type      = size_q;
  assign mem.done      = done_q;
  assign mem.fill_line = line_q;

  // Back-pressure keeps the address on the bus
  a_addr_stable: assert property (
    @(posedge clk) disable iff (rst)
    (mem_req && mem_wait) |=> $stable(mem_addr)
  );

endmodule

`default_nettype wire

// ==== src/l1d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1d_cache (
  input  wire                   clk,
  input  wire                   rst,

  // Core side
  input  wire l1d_pkg::addr_t   core_addr,
  input  wire                   core_req,
  input  wire                   core_write,
  input  wire l1d_pkg::word_t   core_in,
  input  wire l1d_pkg::size_e   core_type,
  output l1d_pkg::word_t        core_out,
  output logic                  core_wait,

  // Memory side
  input  wire l1d_pkg::word_t   mem_rdata,
  input  wire                   mem_wait,
  output logic                  mem_req,
  output l1d_pkg::addr_t        mem_addr,
  output logic                  mem_write,
  output l1d_pkg::word_t        mem_wdata,
  output l1d_pkg::size_e        mem_type
);

  l1d_req_if req_if ();
  l1d_mem_if mem_if ();

  logic           accept;
  logic           lookup;
  logic           byte_write;
  logic           install;
  logic           hit;
  l1d_pkg::word_t rd_word;

  l1d_core_port i_core_port (
    .clk        (clk),
    .rst        (rst),
    .core_addr  (core_addr),
    .core_req   (core_req),
    .core_write (core_write),
    .core_in    (core_in),
    .core_type  (core_type),
    .accept     (accept),
    .req        (req_if.port)
  );

  l1d_line_store i_line_store (
    .clk        (clk),
    .rst        (rst),
    .req        (req_if.sink),
    .lookup     (lookup),
    .byte_write (byte_write),
    .install    (install),
    .fill_line  (mem_if.fill_line),
    .hit        (hit),
    .rd_word    (rd_word)
  );

  l1d_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .accept     (accept),
    .hit        (hit),
    .rd_word    (rd_word),
    .fill_line  (mem_if.fill_line),
    .req        (req_if.sink),
    .mem        (mem_if.ctrl),
    .lookup     (lookup),
    .byte_write (byte_write),
    .install    (install),
    .core_wait  (core_wait),
    .core_out   (core_out)
  );

  l1d_mem_port i_mem_port (
    .clk        (clk),
    .rst        (rst),
    .mem        (mem_if.port),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_type   (mem_type)
  );

endmodule

`default_nettype wire

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   mem_req,
  input  wire l1d_pkg::addr_t   mem_addr,
  input  wire                   mem_write,
  input  wire l1d_pkg::word_t   mem_wdata,
  input  wire l1d_pkg::size_e   mem_type,
  output l1d_pkg::word_t        mem_rdata,
  output logic                  mem_wait
);

  localparam l1d_pkg::addr_t win_base  = 32'h2000_0000;
  localparam int             win_bytes = 16384;  // Window used by the tests
  localparam int             log_depth = 2048;

  logic [7:0]     store [win_bytes];  // Shadow byte store
  l1d_pkg::addr_t log_addr  [log_depth];
  logic           log_write [log_depth];
  l1d_pkg::word_t log_data  [log_depth];
  l1d_pkg::size_e log_type  [log_depth];
  int             n_beats;
  int             stall;
  int             i;

  // Every address bit reaches the top byte of the product
  function automatic logic [7:0] init_byte(input l1d_pkg::addr_t a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;
    return h[31:24];
  endfunction

  function automatic l1d_pkg::word_t read_word(input l1d_pkg::addr_t a);
    l1d_pkg::word_t w;
    int b;
    for (b = 0; b < 4; b++)
      w[b*8 +: 8] = store[{a[13:2], 2'b00} + b];
    return w;
  endfunction

  // Raw core word, placed by the address like a real byte-lane memory
  task automatic apply_write(input l1d_pkg::addr_t a, input l1d_pkg::size_e sz,
                             input l1d_pkg::word_t d);
    case (sz)
      l1d_pkg::size_byte:
        store[a[13:0]] = d[7:0];
      l1d_pkg::size_half:
      begin
        store[{a[13:1], 1'b0}] = d[7:0];
        store[{a[13:1], 1'b1}] = d[15:8];
      end
      default:
      begin
        store[{a[13:2], 2'b00}] = d[7:0];
        store[{a[13:2], 2'b01}] = d[15:8];
        store[{a[13:2], 2'b10}] = d[23:16];
        store[{a[13:2], 2'b11}] = d[31:24];
      end
    endcase
  endtask

  initial
  begin
    mem_rdata = '0;
    mem_wait  = 1'b0;
    for (i = 0; i < win_bytes; i++)
      store[i] = init_byte(win_base + i);
  end

  // ==========================================================
  // Beats, stalls and log
  // ==========================================================
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mem_wait <= 1'b0;
      n_beats  <= 0;
      stall = 0;
    end
    else if (mem_req)
    begin
      if (!mem_wait)  // Beat completes here
      begin
        if (n_beats < log_depth)
        begin
          log_addr[n_beats]  <= mem_addr;
          log_write[n_beats] <= mem_write;
          log_data[n_beats]  <= mem_wdata;
          log_type[n_beats]  <= mem_type;
        end
        n_beats <= n_beats + 1;
        if (mem_write)
          apply_write(mem_addr, mem_type, mem_wdata);
        stall = $urandom_range(3, 0);  // Wait cycles before the next beat
      end
      else
        stall = stall - 1;
      mem_wait <= (stall != 0);
    end
  end

  // Refreshed between edges, so stable when a beat completes
  always @(negedge clk)
    mem_rdata <= read_word(mem_addr);

endmodule

`default_nettype wire

// ==== tests/tb_l1d_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1d_cache;

  localparam int n_directed     = 17;
  localparam int n_random       = 300;
  localparam int timeout_cycles = (n_directed + n_random) * 400;
  localparam int win_bytes      = 16384;

  logic           clk;
  logic           rst;
  l1d_pkg::addr_t core_addr;
  logic           core_req;
  logic           core_write;
  l1d_pkg::word_t core_in;
  l1d_pkg::size_e core_type;
  l1d_pkg::word_t core_out;
  logic           core_wait;
  l1d_pkg::word_t mem_rdata;
  logic           mem_wait;
  logic           mem_req;
  l1d_pkg::addr_t mem_addr;
  logic           mem_write;
  l1d_pkg::word_t mem_wdata;
  l1d_pkg::size_e mem_type;

  logic [7:0]     ref_mem [win_bytes];  // Expected memory image
  l1d_pkg::word_t exp_word;
  int             beats_before;
  int             n_checks;
  int             n_errors;
  int             seed_ret;
  int             idx;
  l1d_pkg::addr_t rnd_addr;
  l1d_pkg::size_e rnd_size;
  logic           rnd_write;

  l1d_cache i_dut (
    .clk        (clk),
    .rst        (rst),
    .core_addr  (core_addr),
    .core_req   (core_req),
    .core_write (core_write),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_out   (core_out),
    .core_wait  (core_wait),
    .mem_rdata  (mem_rdata),
    .mem_wait   (mem_wait),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_type   (mem_type)
  );

  tb_mem_model i_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_write (mem_write),
    .mem_wdata (mem_wdata),
    .mem_type  (mem_type),
    .mem_rdata (mem_rdata),
    .mem_wait  (mem_wait)
  );

  always #2 clk = ~clk;

  // ==========================================================
  // Reference model
  // ==========================================================
  function automatic l1d_pkg::word_t expected_word(input l1d_pkg::addr_t a);
    l1d_pkg::word_t w;
    int i;
    for (i = 0; i < 4; i++)
      w[i*8 +: 8] = ref_mem[{a[13:2], 2'b00} + i];
    return w;
  endfunction

  function automatic l1d_pkg::word_t merge_word(input l1d_pkg::word_t old,
                                                input l1d_pkg::addr_t a,
                                                input l1d_pkg::size_e sz,
                                                input l1d_pkg::word_t d);
    l1d_pkg::word_t m;
    m = old;
    case (sz)
      l1d_pkg::size_byte: m[a[1:0]*8 +: 8] = d[7:0];   // Lane from bits 1:0
      l1d_pkg::size_half: m[a[1]*16 +: 16] = d[15:0];  // Lane from bit 1
      default:            m = d;
    endcase
    return m;
  endfunction

  task automatic record_write(input l1d_pkg::addr_t a, input l1d_pkg::size_e sz,
                              input l1d_pkg::word_t d);
    l1d_pkg::word_t w;
    int i;
    w = merge_word(expected_word(a), a, sz, d);
    for (i = 0; i < 4; i++)
      ref_mem[{a[13:2], 2'b00} + i] = w[i*8 +: 8];
  endtask

  task automatic flag_error(input string msg);
    n_errors++;
    $display("[FAIL] t=%0d ns: %s", $time, msg);
  endtask

  // ==========================================================
  // Core side access and beat checks
  // ==========================================================
  task automatic run_access(input logic wr, input l1d_pkg::addr_t a,
                            input l1d_pkg::size_e sz, input l1d_pkg::word_t d);
    beats_before = i_mem.n_beats;
    if (!wr)
      exp_word = expected_word(a);
    @(posedge clk);
    core_req   <= 1'b1;
    core_write <= wr;
    core_addr  <= a;
    core_type  <= sz;
    core_in    <= d;
    @(negedge clk);
    while (core_wait)
      @(negedge clk);
    @(posedge clk);  // Handshake edge
    core_req <= 1'b0;
    if (wr)
      record_write(a, sz, d);
  endtask

  task automatic check_beat_count(input int n, input string what);
    n_checks++;
    if (i_mem.n_beats - beats_before != n)
      flag_error($sformatf("%s made %0d memory beats, expected %0d",
                           what, i_mem.n_beats - beats_before, n));
  endtask

  task automatic check_refill(input l1d_pkg::addr_t a);
    int i;
    int k;
    check_beat_count(4, "refill");
    for (i = 0; i < 4; i++)
    begin
      k = beats_before + i;
      n_checks++;
      if (i_mem.log_write[k] !== 1'b0 || i_mem.log_addr[k] !== {a[31:4], 4'h0} + 4 * i)
        flag_error($sformatf("refill beat %0d at %h, expected read at %h",
                             i, i_mem.log_addr[k], {a[31:4], 4'h0} + 4 * i));
    end
  endtask

  task automatic issue_read(input l1d_pkg::addr_t a);
    run_access(1'b0, a, l1d_pkg::size_word, '0);
  endtask

  task automatic issue_write(input l1d_pkg::addr_t a, input l1d_pkg::size_e sz,
                             input l1d_pkg::word_t d);
    int k;
    run_access(1'b1, a, sz, d);
    k = beats_before;
    check_beat_count(1, "write-through");
    n_checks++;
    if (i_mem.log_write[k] !== 1'b1 || i_mem.log_addr[k] !== a ||
        i_mem.log_data[k] !== d || i_mem.log_type[k] !== sz)
      flag_error($sformatf("write beat %h/%h/%0d, expected %h/%h/%0d",
                           i_mem.log_addr[k], i_mem.log_data[k], i_mem.log_type[k],
                           a, d, sz));
  endtask

  // Read responses, sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst && core_req && !core_wait && !core_write)
    begin
      n_checks++;
      if (core_out !== exp_word)
        flag_error($sformatf("read %h returned %h, expected %h",
                             core_addr, core_out, exp_word));
    end
  end

  initial
  begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the cache did not finish within %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial
  begin
    seed_ret   = $urandom(25);
    clk        = 1'b0;
    rst        = 1'b1;
    core_addr  = '0;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_in    = '0;
    core_type  = l1d_pkg::size_word;
    exp_word   = '0;
    n_checks   = 0;
    n_errors   = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    n_checks++;
    if (core_wait !== 1'b0 || mem_req !== 1'b0 || mem_write !== 1'b0)
      flag_error("core_wait, mem_req or mem_write high after reset");
    for (idx = 0; idx < win_bytes; idx++)
      ref_mem[idx] = i_mem.store[idx];  // Start from the untouched pattern

    // Read miss then hit in the same line
    issue_read(32'h2000_1108);
    check_refill(32'h2000_1108);
    issue_read(32'h2000_1104);
    check_beat_count(0, "read hit");

    // Write hits at several lanes
    issue_read(32'h2000_1240);
    check_refill(32'h2000_1240);
    issue_write(32'h2000_1241, l1d_pkg::size_byte, 32'h0000_00a5);
    issue_write(32'h2000_1242, l1d_pkg::size_half, 32'h0000_1234);
    issue_write(32'h2000_1247, l1d_pkg::size_byte, 32'h0000_003c);
    issue_write(32'h2000_1248, l1d_pkg::size_half, 32'h0000_beef);
    issue_write(32'h2000_124c, l1d_pkg::size_word, 32'h1357_9bdf);
    for (idx = 0; idx < 4; idx++)
    begin
      issue_read(32'h2000_1240 + 4 * idx);
      check_beat_count(0, "read after write hit");
    end

    // Write miss leaves the line uncached
    issue_write(32'h2000_2304, l1d_pkg::size_word, 32'hcafe_f00d);
    issue_read(32'h2000_2304);
    check_refill(32'h2000_2304);

    // Same index, different tags
    issue_read(32'h2000_3050);
    check_refill(32'h2000_3050);
    issue_read(32'h2000_3450);
    check_refill(32'h2000_3450);
    issue_read(32'h2000_3050);
    check_refill(32'h2000_3050);

    // Random mix over four tags and 16 indices
    for (idx = 0; idx < n_random; idx++)
    begin
      rnd_addr = 32'h2000_0000 | ($urandom_range(3, 0) << 10) |
                 ($urandom_range(15, 0) << 4) | $urandom_range(15, 0);
      rnd_size = l1d_pkg::size_e'($urandom_range(2, 0));
      if (rnd_size == l1d_pkg::size_half)
        rnd_addr[0] = 1'b0;
      else if (rnd_size == l1d_pkg::size_word)
        rnd_addr[1:0] = 2'b00;
      rnd_write = $urandom_range(1, 0);
      if (rnd_write)
        issue_write(rnd_addr, rnd_size, $urandom);
      else
        issue_read(rnd_addr);
    end

    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== l1d_cache.f ====
+incdir+src
src/l1d_pkg.sv
src/l1d_if.sv
src/l1d_core_port.sv
src/l1d_line_store.sv
src/l1d_ctrl.sv
src/l1d_mem_port.sv
src/l1d_cache.sv
tests/tb_mem_model.sv
tests/tb_l1d_cache.sv

// ==== Bender.yml ====
package:
  name: l1d_cache

sources:
  - include_dirs:
      - src
    files:
      - src/l1d_pkg.sv
      - src/l1d_if.sv
      - src/l1d_core_port.sv
      - src/l1d_line_store.sv
      - src/l1d_ctrl.sv
      - src/l1d_mem_port.sv
      - src/l1d_cache.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_l1d_cache.sv
